// File: logic/trace_defines.svh
`ifndef TRACE_DEFINES_SVH
`define TRACE_DEFINES_SVH

// Byte PC is the word-address PC followed by two zero bits
`define TRACE_PC_W 30

`define TRACE_DATA_W 32
`define TRACE_DMEM_ADDR_W 10
`define TRACE_REG_ADDR_W 5

// FPU register file keeps floats in 33-bit recoded form
`define TRACE_RECFN_W 33

`define TRACE_FIFO_DEPTH 8

// Saturating counters
`define TRACE_STALL_CNT_W 8
`define TRACE_DROP_W 16

`endif

// File: logic/trace_pkg.sv
`default_nettype none

`include "trace_defines.svh"

package trace_pkg;

  // Listed in priority order with IFETCH highest
  typedef enum logic [1:0] {
    STALL_NONE,
    STALL_IFETCH,
    STALL_LOADWB,
    STALL_FLWWB
  } stall_reason_e;

  typedef enum logic [2:0] {
    ACC_NONE,
    ACC_LOCAL_LOAD,
    ACC_LOCAL_STORE,
    ACC_REMOTE_LOAD,
    ACC_REMOTE_STORE
  } access_e;

  typedef struct packed {
    logic [`TRACE_DATA_W-1:0] pc;
    logic [`TRACE_DATA_W-1:0] instr;
    logic is_branch;
    logic [`TRACE_DATA_W-1:0] btarget;
    access_e access;
    // Dmem word address or remote address, zero-extended
    logic [`TRACE_DATA_W-1:0] addr;
    logic [`TRACE_DATA_W-1:0] data;
    logic int_wen;
    logic [`TRACE_REG_ADDR_W-1:0] int_waddr;
    logic [`TRACE_DATA_W-1:0] int_wdata;
    logic fp_wen;
    logic [`TRACE_REG_ADDR_W-1:0] fp_waddr;
    // IEEE single precision
    logic [`TRACE_DATA_W-1:0] fp_wdata;
    stall_reason_e stall_reason;
    logic [`TRACE_STALL_CNT_W-1:0] stall_cycles;
  } trace_rec_t;

endpackage

`default_nettype wire

// File: logic/trace_stage_pipe.sv
`timescale 1ns/1ns
`default_nettype none

`include "trace_defines.svh"

module trace_stage_pipe (
  input  wire logic                          clk_i,
  input  wire logic                          reset_i,
  input  wire logic                          stall_all_i,
  input  wire logic                          exe_v_i,
  input  wire logic [`TRACE_DATA_W-1:0]      exe_pc_plus4_i,
  input  wire logic [`TRACE_DATA_W-1:0]      exe_instr_i,
  input  wire logic                          exe_branch_i,
  input  wire logic                          exe_jal_i,
  input  wire logic                          exe_jalr_i,
  input  wire logic [`TRACE_PC_W-1:0]        pc_next_i,
  input  wire logic                          dmem_v_i,
  input  wire logic                          dmem_w_i,
  input  wire logic [`TRACE_DMEM_ADDR_W-1:0] dmem_addr_i,
  input  wire logic [`TRACE_DATA_W-1:0]      dmem_wdata_i,
  input  wire logic [`TRACE_DATA_W-1:0]      dmem_rdata_i,
  input  wire logic                          remote_v_i,
  input  wire logic                          remote_write_i,
  input  wire logic                          remote_icache_fetch_i,
  input  wire logic [`TRACE_DATA_W-1:0]      remote_addr_i,
  input  wire logic [`TRACE_DATA_W-1:0]      remote_wdata_i,
  output logic                               wb_v_o,
  output logic [`TRACE_DATA_W-1:0]           wb_pc_o,
  output logic [`TRACE_DATA_W-1:0]           wb_instr_o,
  output logic                               wb_branch_o,
  output logic [`TRACE_DATA_W-1:0]           wb_btarget_o,
  output trace_pkg::access_e                 wb_access_o,
  output logic [`TRACE_DATA_W-1:0]           wb_addr_o,
  output logic [`TRACE_DATA_W-1:0]           wb_data_o
);

  logic [`TRACE_DATA_W-1:0] exe_addr_w;
  logic [`TRACE_DATA_W-1:0] exe_data_w;
  trace_pkg::access_e       exe_access_w;

  logic                     mem_v_r;
  logic [`TRACE_DATA_W-1:0] mem_pc_r;
  logic [`TRACE_DATA_W-1:0] mem_instr_r;
  logic                     mem_branch_r;
  logic [`TRACE_DATA_W-1:0] mem_btarget_r;
  trace_pkg::access_e       mem_access_r;
  logic [`TRACE_DATA_W-1:0] mem_addr_r;
  logic [`TRACE_DATA_W-1:0] mem_data_r;

  // Local dmem request beats a remote one
  always_comb begin
    exe_access_w = trace_pkg::ACC_NONE;
    exe_addr_w   = '0;
    exe_data_w   = '0;
    if (dmem_v_i) begin
      exe_addr_w = {{(`TRACE_DATA_W-`TRACE_DMEM_ADDR_W){1'b0}}, dmem_addr_i};
      if (dmem_w_i) begin
        exe_access_w = trace_pkg::ACC_LOCAL_STORE;
        exe_data_w   = dmem_wdata_i;
      end else begin
        exe_access_w = trace_pkg::ACC_LOCAL_LOAD;
      end
    end else if (remote_v_i && remote_write_i) begin
      exe_access_w = trace_pkg::ACC_REMOTE_STORE;
      exe_addr_w   = remote_addr_i;
      exe_data_w   = remote_wdata_i;
    end else if (remote_v_i && !remote_icache_fetch_i) begin
      exe_access_w = trace_pkg::ACC_REMOTE_LOAD;
      exe_addr_w   = remote_addr_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mem_v_r <= 1'b0;
      wb_v_o  <= 1'b0;
    end else if (!stall_all_i) begin
      mem_v_r <= exe_v_i;
      wb_v_o  <= mem_v_r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_all_i) begin
      mem_pc_r      <= exe_pc_plus4_i - `TRACE_DATA_W'(4);
      mem_instr_r   <= exe_instr_i;
      mem_branch_r  <= exe_branch_i | exe_jal_i | exe_jalr_i;
      mem_btarget_r <= {pc_next_i, 2'b00};
      mem_access_r  <= exe_access_w;
      mem_addr_r    <= exe_addr_w;
      mem_data_r    <= exe_data_w;

      wb_pc_o      <= mem_pc_r;
      wb_instr_o   <= mem_instr_r;
      wb_branch_o  <= mem_branch_r;
      wb_btarget_o <= mem_btarget_r;
      wb_access_o  <= mem_access_r;
      wb_addr_o    <= mem_addr_r;
      // Read data shows up during MEM
      wb_data_o    <= (mem_access_r == trace_pkg::ACC_LOCAL_LOAD) ? dmem_rdata_i : mem_data_r;
    end
  end

endmodule

`default_nettype wire

// File: logic/recfn_to_fn.sv
`timescale 1ns/1ns
`default_nettype none

`include "trace_defines.svh"

module recfn_to_fn (
  input  wire logic [`TRACE_RECFN_W-1:0] rec_i,
  output logic [`TRACE_DATA_W-1:0]       ieee_o
);

  localparam int frac_w_lp = 23;
  localparam int exp_w_lp  = `TRACE_RECFN_W - frac_w_lp - 1;

  logic                sign_w;
  logic [exp_w_lp-1:0] exp_w;
  logic [frac_w_lp-1:0] frac_w;
  logic [7:0]          norm_exp_w;
  logic [exp_w_lp-1:0] shift_w;
  logic [frac_w_lp:0]  sub_sig_w;

  assign sign_w = rec_i[`TRACE_RECFN_W-1];
  assign exp_w  = rec_i[`TRACE_RECFN_W-2 -: exp_w_lp];
  assign frac_w = rec_i[frac_w_lp-1:0];

  // Recoded bias is 129 above the IEEE exponent
  assign norm_exp_w = 8'(exp_w - exp_w_lp'(129));

  // Exponent 130 maps to IEEE exponent 1 and each step below is one more shift
  assign shift_w   = exp_w_lp'(130) - exp_w;
  assign sub_sig_w = {1'b1, frac_w} >> shift_w;

  always_comb begin
    case (exp_w[exp_w_lp-1 -: 3])
      3'b000: begin
        ieee_o = {sign_w, 8'h00, {frac_w_lp{1'b0}}};
      end
      3'b110: begin
        ieee_o = {sign_w, 8'hff, {frac_w_lp{1'b0}}};
      end
      3'b111: begin
        // NaN payload travels unchanged
        ieee_o = {sign_w, 8'hff, frac_w};
      end
      default: begin
        if (exp_w < exp_w_lp'(130)) begin
          ieee_o = {sign_w, 8'h00, sub_sig_w[frac_w_lp-1:0]};
        end else begin
          ieee_o = {sign_w, norm_exp_w, frac_w};
        end
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/trace_record_builder.sv
`timescale 1ns/1ns
`default_nettype none

`include "trace_defines.svh"

module trace_record_builder (
  input  wire logic                         clk_i,
  input  wire logic                         reset_i,
  input  wire logic                         stall_all_i,
  input  wire logic                         stall_ifetch_i,
  input  wire logic                         stall_loadwb_i,
  input  wire logic                         stall_flwwb_i,
  input  wire logic                         wb_v_i,
  input  wire logic [`TRACE_DATA_W-1:0]     wb_pc_i,
  input  wire logic [`TRACE_DATA_W-1:0]     wb_instr_i,
  input  wire logic                         wb_branch_i,
  input  wire logic [`TRACE_DATA_W-1:0]     wb_btarget_i,
  input  wire trace_pkg::access_e           wb_access_i,
  input  wire logic [`TRACE_DATA_W-1:0]     wb_addr_i,
  input  wire logic [`TRACE_DATA_W-1:0]     wb_data_i,
  input  wire logic                         int_wen_i,
  input  wire logic [`TRACE_REG_ADDR_W-1:0] int_waddr_i,
  input  wire logic [`TRACE_DATA_W-1:0]     int_wdata_i,
  input  wire logic                         fp_wen_i,
  input  wire logic [`TRACE_REG_ADDR_W-1:0] fp_waddr_i,
  input  wire logic [`TRACE_DATA_W-1:0]     fp_ieee_i,
  output logic                              push_o,
  output trace_pkg::trace_rec_t             rec_o
);

  logic [`TRACE_STALL_CNT_W-1:0] stall_cnt_r;
  trace_pkg::stall_reason_e      stall_reason_r;
  trace_pkg::stall_reason_e      reason_w;

  always_comb begin
    if (stall_ifetch_i) begin
      reason_w = trace_pkg::STALL_IFETCH;
    end else if (stall_loadwb_i) begin
      reason_w = trace_pkg::STALL_LOADWB;
    end else if (stall_flwwb_i) begin
      reason_w = trace_pkg::STALL_FLWWB;
    end else begin
      reason_w = trace_pkg::STALL_NONE;
    end
  end

  // Only cycles spent by a valid instruction in WB count
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stall_cnt_r    <= '0;
      stall_reason_r <= trace_pkg::STALL_NONE;
    end else if (wb_v_i) begin
      if (stall_all_i) begin
        if (stall_cnt_r != '1) begin
          stall_cnt_r <= stall_cnt_r + 1'b1;
        end
        stall_reason_r <= reason_w;
      end else begin
        stall_cnt_r    <= '0;
        stall_reason_r <= trace_pkg::STALL_NONE;
      end
    end
  end

  assign push_o = wb_v_i & ~stall_all_i;

  always_comb begin
    rec_o.pc           = wb_pc_i;
    rec_o.instr        = wb_instr_i;
    rec_o.is_branch    = wb_branch_i;
    rec_o.btarget      = wb_btarget_i;
    rec_o.access       = wb_access_i;
    rec_o.addr         = wb_addr_i;
    rec_o.data         = wb_data_i;
    rec_o.int_wen      = int_wen_i;
    rec_o.int_waddr    = int_waddr_i;
    rec_o.int_wdata    = int_wdata_i;
    rec_o.fp_wen       = fp_wen_i;
    rec_o.fp_waddr     = fp_waddr_i;
    rec_o.fp_wdata     = fp_ieee_i;
    rec_o.stall_reason = stall_reason_r;
    rec_o.stall_cycles = stall_cnt_r;
  end

endmodule

`default_nettype wire

// File: logic/trace_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "trace_defines.svh"

module trace_fifo #(
  parameter int depth_p = `TRACE_FIFO_DEPTH
) (
  input  wire logic                     clk_i,
  input  wire logic                     reset_i,
  input  wire logic                     push_i,
  input  wire trace_pkg::trace_rec_t    push_rec_i,
  output logic                          valid_o,
  output trace_pkg::trace_rec_t         rec_o,
  input  wire logic                     ready_i,
  output logic [`TRACE_DROP_W-1:0]      drop_count_o
);

  localparam int ptr_w_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int cnt_w_lp = $clog2(depth_p + 1);
  localparam logic [ptr_w_lp-1:0] last_lp = ptr_w_lp'(depth_p - 1);

  trace_pkg::trace_rec_t mem_r [depth_p];

  logic [ptr_w_lp-1:0] wr_ptr_r;
  logic [ptr_w_lp-1:0] rd_ptr_r;
  logic [cnt_w_lp-1:0] count_r;
  logic                full_w;
  logic                push_ok_w;
  logic                pop_w;

  // Room is judged at cycle start so a same-cycle pop does not help
  assign full_w    = (count_r == cnt_w_lp'(depth_p));
  assign push_ok_w = push_i & ~full_w;
  assign pop_w     = valid_o & ready_i;

  assign valid_o = (count_r != '0);
  assign rec_o   = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r     <= '0;
      rd_ptr_r     <= '0;
      count_r      <= '0;
      drop_count_o <= '0;
    end else begin
      if (push_ok_w) begin
        wr_ptr_r <= (wr_ptr_r == last_lp) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop_w) begin
        rd_ptr_r <= (rd_ptr_r == last_lp) ? '0 : rd_ptr_r + 1'b1;
      end
      count_r <= count_r + cnt_w_lp'(push_ok_w) - cnt_w_lp'(pop_w);
      if (push_i && full_w && drop_count_o != '1) begin
        drop_count_o <= drop_count_o + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_ok_w) begin
      mem_r[wr_ptr_r] <= push_rec_i;
    end
  end

endmodule

`default_nettype wire

// File: logic/core_trace_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "trace_defines.svh"

module core_trace_top (
  input  wire logic                          clk_i,
  input  wire logic                          reset_i,
  input  wire logic                          exe_v_i,
  input  wire logic [`TRACE_DATA_W-1:0]      exe_pc_plus4_i,
  input  wire logic [`TRACE_DATA_W-1:0]      exe_instr_i,
  input  wire logic                          exe_branch_i,
  input  wire logic                          exe_jal_i,
  input  wire logic                          exe_jalr_i,
  input  wire logic [`TRACE_PC_W-1:0]        pc_next_i,
  input  wire logic                          dmem_v_i,
  input  wire logic                          dmem_w_i,
  input  wire logic [`TRACE_DMEM_ADDR_W-1:0] dmem_addr_i,
  input  wire logic [`TRACE_DATA_W-1:0]      dmem_wdata_i,
  input  wire logic [`TRACE_DATA_W-1:0]      dmem_rdata_i,
  input  wire logic                          remote_v_i,
  input  wire logic                          remote_write_i,
  input  wire logic                          remote_icache_fetch_i,
  input  wire logic [`TRACE_DATA_W-1:0]      remote_addr_i,
  input  wire logic [`TRACE_DATA_W-1:0]      remote_wdata_i,
  input  wire logic                          int_wen_i,
  input  wire logic [`TRACE_REG_ADDR_W-1:0]  int_waddr_i,
  input  wire logic [`TRACE_DATA_W-1:0]      int_wdata_i,
  input  wire logic                          fp_wen_i,
  input  wire logic [`TRACE_REG_ADDR_W-1:0]  fp_waddr_i,
  input  wire logic [`TRACE_RECFN_W-1:0]     fp_wdata_i,
  input  wire logic                          stall_all_i,
  input  wire logic                          stall_ifetch_i,
  input  wire logic                          stall_loadwb_i,
  input  wire logic                          stall_flwwb_i,
  output logic                               trace_valid_o,
  output trace_pkg::trace_rec_t              trace_rec_o,
  input  wire logic                          trace_ready_i,
  output logic [`TRACE_DROP_W-1:0]           drop_count_o
);

  logic                     wb_v;
  logic [`TRACE_DATA_W-1:0] wb_pc;
  logic [`TRACE_DATA_W-1:0] wb_instr;
  logic                     wb_branch;
  logic [`TRACE_DATA_W-1:0] wb_btarget;
  trace_pkg::access_e       wb_access;
  logic [`TRACE_DATA_W-1:0] wb_addr;
  logic [`TRACE_DATA_W-1:0] wb_data;
  logic [`TRACE_DATA_W-1:0] fp_ieee;
  logic                     push;
  trace_pkg::trace_rec_t    push_rec;

  trace_stage_pipe pipe_i (
    .clk_i,
    .reset_i,
    .stall_all_i,
    .exe_v_i,
    .exe_pc_plus4_i,
    .exe_instr_i,
    .exe_branch_i,
    .exe_jal_i,
    .exe_jalr_i,
    .pc_next_i,
    .dmem_v_i,
    .dmem_w_i,
    .dmem_addr_i,
    .dmem_wdata_i,
    .dmem_rdata_i,
    .remote_v_i,
    .remote_write_i,
    .remote_icache_fetch_i,
    .remote_addr_i,
    .remote_wdata_i,
    .wb_v_o       (wb_v),
    .wb_pc_o      (wb_pc),
    .wb_instr_o   (wb_instr),
    .wb_branch_o  (wb_branch),
    .wb_btarget_o (wb_btarget),
    .wb_access_o  (wb_access),
    .wb_addr_o    (wb_addr),
    .wb_data_o    (wb_data)
  );

  // FP register writes arrive recoded
  recfn_to_fn fp_conv_i (
    .rec_i  (fp_wdata_i),
    .ieee_o (fp_ieee)
  );

  trace_record_builder builder_i (
    .clk_i,
    .reset_i,
    .stall_all_i,
    .stall_ifetch_i,
    .stall_loadwb_i,
    .stall_flwwb_i,
    .wb_v_i       (wb_v),
    .wb_pc_i      (wb_pc),
    .wb_instr_i   (wb_instr),
    .wb_branch_i  (wb_branch),
    .wb_btarget_i (wb_btarget),
    .wb_access_i  (wb_access),
    .wb_addr_i    (wb_addr),
    .wb_data_i    (wb_data),
    .int_wen_i,
    .int_waddr_i,
    .int_wdata_i,
    .fp_wen_i,
    .fp_waddr_i,
    .fp_ieee_i    (fp_ieee),
    .push_o       (push),
    .rec_o        (push_rec)
  );

  trace_fifo #(
    .depth_p (`TRACE_FIFO_DEPTH)
  ) fifo_i (
    .clk_i,
    .reset_i,
    .push_i       (push),
    .push_rec_i   (push_rec),
    .valid_o      (trace_valid_o),
    .rec_o        (trace_rec_o),
    .ready_i      (trace_ready_i),
    .drop_count_o
  );

endmodule

`default_nettype wire

// File: tb/core_trace_model.svh
`ifndef CORE_TRACE_MODEL_SVH
`define CORE_TRACE_MODEL_SVH

// Shadow slots carry the fields known before writeback
logic                          m_mem_v;
trace_pkg::trace_rec_t         m_mem;
logic                          m_wb_v;
trace_pkg::trace_rec_t         m_wb;
logic [`TRACE_STALL_CNT_W-1:0] m_stall_cnt;
trace_pkg::stall_reason_e      m_reason;
trace_pkg::trace_rec_t         m_fifo[$];
logic [`TRACE_DROP_W-1:0]      m_drops;
int                            m_delivered;
logic                          m_saw_drop;
logic                          m_saw_sat;

// IEEE single to 33-bit recoded form
function automatic logic [`TRACE_RECFN_W-1:0] recode_float(input logic [31:0] f);
  logic [7:0]  e;
  logic [22:0] frac;
  logic [8:0]  rexp;
  int          lead;
  e = f[30:23];
  frac = f[22:0];
  lead = 0;
  if (e == 8'hff) begin
    rexp = (frac == '0) ? 9'h180 : 9'h1c0;
  end else if (e != 8'h00) begin
    rexp = 9'(e) + 9'd129;
  end else if (frac == '0) begin
    rexp = 9'h000;
  end else begin
    for (int i = 0; i < 23; i++) begin
      if (frac[i]) begin
        lead = i;
      end
    end
    // Normalize so the leading one becomes the hidden bit
    rexp = 9'(107 + lead);
    frac = frac << (23 - lead);
  end
  return {f[31], rexp, frac};
endfunction

function automatic trace_pkg::trace_rec_t classify_exe();
  trace_pkg::trace_rec_t r;
  r = '0;
  r.pc = exe_pc_plus4_i - 32'd4;
  r.instr = exe_instr_i;
  r.is_branch = exe_branch_i || exe_jal_i || exe_jalr_i;
  r.btarget = {pc_next_i, 2'b00};
  r.access = trace_pkg::ACC_NONE;
  if (dmem_v_i) begin
    r.addr = 32'(dmem_addr_i);
    if (dmem_w_i) begin
      r.access = trace_pkg::ACC_LOCAL_STORE;
      r.data = dmem_wdata_i;
    end else begin
      r.access = trace_pkg::ACC_LOCAL_LOAD;
    end
  end else if (remote_v_i && remote_write_i) begin
    r.access = trace_pkg::ACC_REMOTE_STORE;
    r.addr = remote_addr_i;
    r.data = remote_wdata_i;
  end else if (remote_v_i && !remote_icache_fetch_i) begin
    r.access = trace_pkg::ACC_REMOTE_LOAD;
    r.addr = remote_addr_i;
  end
  return r;
endfunction

// One clock edge with the inputs driven for this cycle
task automatic model_step();
  trace_pkg::trace_rec_t rec;
  logic                  full;
  logic                  retire;
  full = (m_fifo.size() == `TRACE_FIFO_DEPTH);
  retire = m_wb_v && !stall_all_i;
  rec = m_wb;
  rec.int_wen = int_wen_i;
  rec.int_waddr = int_waddr_i;
  rec.int_wdata = int_wdata_i;
  rec.fp_wen = fp_wen_i;
  rec.fp_waddr = fp_waddr_i;
  rec.fp_wdata = fp_ieee_sent;
  rec.stall_reason = m_reason;
  rec.stall_cycles = m_stall_cnt;
  if (reset_i) begin
    m_fifo.delete();
    m_drops = '0;
    m_stall_cnt = '0;
    m_reason = trace_pkg::STALL_NONE;
  end else begin
    if (m_fifo.size() != 0 && trace_ready_i) begin
      void'(m_fifo.pop_front());
      m_delivered++;
    end
    if (retire) begin
      if (m_stall_cnt == '1) begin
        m_saw_sat = 1'b1;
      end
      if (full) begin
        m_saw_drop = 1'b1;
        if (m_drops != '1) begin
          m_drops++;
        end
      end else begin
        m_fifo.push_back(rec);
      end
    end
    if (m_wb_v && stall_all_i) begin
      if (m_stall_cnt != '1) begin
        m_stall_cnt++;
      end
      if (stall_ifetch_i) begin
        m_reason = trace_pkg::STALL_IFETCH;
      end else if (stall_loadwb_i) begin
        m_reason = trace_pkg::STALL_LOADWB;
      end else if (stall_flwwb_i) begin
        m_reason = trace_pkg::STALL_FLWWB;
      end else begin
        m_reason = trace_pkg::STALL_NONE;
      end
    end else if (m_wb_v) begin
      m_stall_cnt = '0;
      m_reason = trace_pkg::STALL_NONE;
    end
  end
  if (!stall_all_i) begin
    m_wb = m_mem;
    if (m_mem.access == trace_pkg::ACC_LOCAL_LOAD) begin
      m_wb.data = dmem_rdata_i;
    end
    m_wb_v = m_mem_v;
    m_mem = classify_exe();
    m_mem_v = exe_v_i;
  end
  if (reset_i) begin
    m_mem_v = 1'b0;
    m_wb_v = 1'b0;
  end
endtask

`endif

// File: tb/core_trace_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "trace_defines.svh"

module core_trace_tb;

  localparam int phase_cycles_lp = 400;
  localparam int drain_cycles_lp = 40;
  localparam int total_cycles_lp = 16 + 8 + 6 * phase_cycles_lp + 4 + drain_cycles_lp + 1;

  logic                          clk_i;
  logic                          reset_i;
  logic                          exe_v_i;
  logic [`TRACE_DATA_W-1:0]      exe_pc_plus4_i;
  logic [`TRACE_DATA_W-1:0]      exe_instr_i;
  logic                          exe_branch_i;
  logic                          exe_jal_i;
  logic                          exe_jalr_i;
  logic [`TRACE_PC_W-1:0]        pc_next_i;
  logic                          dmem_v_i;
  logic                          dmem_w_i;
  logic [`TRACE_DMEM_ADDR_W-1:0] dmem_addr_i;
  logic [`TRACE_DATA_W-1:0]      dmem_wdata_i;
  logic [`TRACE_DATA_W-1:0]      dmem_rdata_i;
  logic                          remote_v_i;
  logic                          remote_write_i;
  logic                          remote_icache_fetch_i;
  logic [`TRACE_DATA_W-1:0]      remote_addr_i;
  logic [`TRACE_DATA_W-1:0]      remote_wdata_i;
  logic                          int_wen_i;
  logic [`TRACE_REG_ADDR_W-1:0]  int_waddr_i;
  logic [`TRACE_DATA_W-1:0]      int_wdata_i;
  logic                          fp_wen_i;
  logic [`TRACE_REG_ADDR_W-1:0]  fp_waddr_i;
  logic [`TRACE_RECFN_W-1:0]     fp_wdata_i;
  logic                          stall_all_i;
  logic                          stall_ifetch_i;
  logic                          stall_loadwb_i;
  logic                          stall_flwwb_i;
  logic                          trace_valid_o;
  trace_pkg::trace_rec_t         trace_rec_o;
  logic                          trace_ready_i;
  logic [`TRACE_DROP_W-1:0]      drop_count_o;

  logic [31:0] rng_state;
  logic [31:0] fp_ieee_sent;
  logic [31:0] pc_ctr;
  int          burst_left;

  `include "core_trace_model.svh"

  core_trace_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Mix of zero, infinity, NaN, subnormal and normal values
  function automatic logic [31:0] random_float();
    logic [31:0] sel;
    logic [31:0] f;
    sel = next_rand();
    f = next_rand();
    case (sel[2:0])
      3'd0: f[30:0] = '0;
      3'd1: f[30:0] = {8'hff, 23'h0};
      3'd2: f[30:0] = {8'hff, f[22:1], 1'b1};
      3'd3: f[30:0] = {8'h00, (f[22:0] >> sel[7:3]) | 23'h1};
      default: begin
        if (f[30:23] == 8'h00 || f[30:23] == 8'hff) begin
          f[30:23] = 8'h7f;
        end
      end
    endcase
    return f;
  endfunction

  task automatic stop_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_rec(input trace_pkg::trace_rec_t got, input trace_pkg::trace_rec_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: trace_rec_o got %h expected %h", $time, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic compare_drops(input logic [`TRACE_DROP_W-1:0] got,
                               input logic [`TRACE_DROP_W-1:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: drop_count_o got %0d expected %0d", $time, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s got %b expected %b", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_outputs();
    compare_flag("trace_valid_o", trace_valid_o, m_fifo.size() != 0);
    if (m_fifo.size() != 0) begin
      compare_rec(trace_rec_o, m_fifo[0]);
    end
    compare_drops(drop_count_o, m_drops);
  endtask

  task automatic drive_inputs(input int stall_rate, input int ready_rate, input int exe_rate,
                              input logic rst);
    logic [31:0] r;
    logic [31:0] s;
    r = next_rand();
    s = next_rand();
    reset_i = rst;
    if (burst_left == 0 && int'(s[7:0]) < stall_rate) begin
      burst_left = 1 + int'(s[10:8]);
    end
    stall_all_i = (burst_left != 0);
    if (burst_left != 0) begin
      burst_left--;
    end
    stall_ifetch_i = s[11] & s[12];
    stall_loadwb_i = s[13];
    stall_flwwb_i = s[14];
    trace_ready_i = (int'(s[22:15]) < ready_rate);
    exe_v_i = (int'(r[7:0]) < exe_rate);
    exe_branch_i = (r[10:8] == 3'd0);
    exe_jal_i = (r[13:11] == 3'd0);
    exe_jalr_i = (r[16:14] == 3'd0);
    dmem_v_i = (r[18:17] == 2'd0);
    dmem_w_i = r[19];
    remote_v_i = (r[21:20] == 2'd0);
    remote_write_i = r[22];
    remote_icache_fetch_i = r[23];
    int_wen_i = r[24];
    fp_wen_i = r[25];
    int_waddr_i = r[30:26];
    fp_waddr_i = s[27:23];
    exe_pc_plus4_i = pc_ctr + 32'd4;
    if (exe_v_i && !stall_all_i) begin
      pc_ctr = pc_ctr + 32'd4;
    end
    exe_instr_i = next_rand();
    r = next_rand();
    pc_next_i = r[29:0];
    dmem_addr_i = s[9:0] ^ r[31:22];
    dmem_wdata_i = next_rand();
    dmem_rdata_i = next_rand();
    remote_addr_i = next_rand();
    remote_wdata_i = next_rand();
    int_wdata_i = next_rand();
    fp_ieee_sent = random_float();
    fp_wdata_i = recode_float(fp_ieee_sent);
  endtask

  task automatic run_cycles(input int n, input int stall_rate, input int ready_rate,
                            input int exe_rate, input logic rst);
    for (int i = 0; i < n; i++) begin
      @(posedge clk_i);
      #1;
      check_outputs();
      drive_inputs(stall_rate, ready_rate, exe_rate, rst);
      model_step();
    end
  endtask

  initial begin
    #(total_cycles_lp * 8 * 2);
    $display("Timeout: the test sequence did not finish within the watchdog limit");
    stop_with_failure();
  end

  initial begin
    rng_state = 32'd81;
    pc_ctr = 32'h0000_1000;
    burst_left = 0;
    fp_ieee_sent = '0;
    reset_i = 1'b1;
    exe_v_i = 1'b0;
    exe_pc_plus4_i = '0;
    exe_instr_i = '0;
    exe_branch_i = 1'b0;
    exe_jal_i = 1'b0;
    exe_jalr_i = 1'b0;
    pc_next_i = '0;
    dmem_v_i = 1'b0;
    dmem_w_i = 1'b0;
    dmem_addr_i = '0;
    dmem_wdata_i = '0;
    dmem_rdata_i = '0;
    remote_v_i = 1'b0;
    remote_write_i = 1'b0;
    remote_icache_fetch_i = 1'b0;
    remote_addr_i = '0;
    remote_wdata_i = '0;
    int_wen_i = 1'b0;
    int_waddr_i = '0;
    int_wdata_i = '0;
    fp_wen_i = 1'b0;
    fp_waddr_i = '0;
    fp_wdata_i = '0;
    stall_all_i = 1'b0;
    stall_ifetch_i = 1'b0;
    stall_loadwb_i = 1'b0;
    stall_flwwb_i = 1'b0;
    trace_ready_i = 1'b1;
    m_mem_v = 1'b0;
    m_wb_v = 1'b0;
    m_mem = '0;
    m_wb = '0;
    m_stall_cnt = '0;
    m_reason = trace_pkg::STALL_NONE;
    m_drops = '0;
    m_delivered = 0;
    m_saw_drop = 1'b0;
    m_saw_sat = 1'b0;
    run_cycles(16, 0, 256, 0, 1'b1);
    // Free-running pipe with the host always ready
    run_cycles(phase_cycles_lp, 0, 256, 200, 1'b0);
    // Fill all slots, then stall past the counter range
    run_cycles(8, 0, 256, 256, 1'b0);
    burst_left = 300;
    run_cycles(phase_cycles_lp, 40, 256, 200, 1'b0);
    // Slow host lets the FIFO overflow
    run_cycles(phase_cycles_lp, 0, 48, 230, 1'b0);
    run_cycles(phase_cycles_lp, 40, 128, 200, 1'b0);
    // Reset in the middle of traffic
    run_cycles(4, 30, 128, 200, 1'b1);
    run_cycles(phase_cycles_lp, 30, 160, 200, 1'b0);
    run_cycles(phase_cycles_lp, 60, 96, 220, 1'b0);
    run_cycles(drain_cycles_lp, 0, 256, 0, 1'b0);
    @(posedge clk_i);
    #1;
    check_outputs();
    if (m_fifo.size() != 0 || m_delivered == 0 || !m_saw_drop || !m_saw_sat) begin
      $display("Run incomplete: %0d records delivered, %0d left",
               m_delivered, m_fifo.size());
      $display("Drop seen %0b, saturation seen %0b", m_saw_drop, m_saw_sat);
      $display("Simulation finished: FAIL");
      $fatal(1, "run ended without reaching every behavior");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+logic
+incdir+tb
logic/trace_pkg.sv
logic/trace_stage_pipe.sv
logic/recfn_to_fn.sv
logic/trace_record_builder.sv
logic/trace_fifo.sv
logic/core_trace_top.sv
tb/core_trace_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the trace unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module core_trace_tb -f tb.f -o core_trace_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/core_trace_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
  exit 0
else
  echo "Pass message not found in sim.log"
  exit 1
fi
